// ==== design/isu_macros.svh ====
`ifndef ISU_MACROS_SVH
`define ISU_MACROS_SVH

// data and pc width
`define ISU_XLEN 32
`define ISU_REG_ADDR_W 5
// one-hot alu operation
`define ISU_ALU_OP_W 16

// instruction pairs held in the issue queue
`define ISU_IQ_DEPTH 8
// ex2, ex1, mem2, mem1
`define ISU_NUM_BYPASS 4

`endif

// ==== design/isu_pkg.sv ====
`include "isu_macros.svh"

package isu_pkg;

    // one decoded instruction as it leaves the decoder
    typedef struct packed {
        logic [`ISU_ALU_OP_W-1:0] alu_op;
        logic [`ISU_XLEN-1:0] imm;
        logic [`ISU_XLEN-1:0] pc;
        logic [`ISU_REG_ADDR_W-1:0] rs1;
        logic [`ISU_REG_ADDR_W-1:0] rs2;
        logic [`ISU_REG_ADDR_W-1:0] dest;
        logic gr_we;
        logic mem_we;
        logic res_from_mem;
        logic src1_is_pc;
        logic src2_is_imm;
        logic is_branch;
        logic pred_taken;
    } inst_t;

    typedef struct packed {
        inst_t first;
        inst_t second;
    } inst_pair_t;

    typedef struct packed {
        logic valid;
        inst_t inst;
    } slot_req_t;

    typedef struct packed {
        logic we;
        logic [`ISU_REG_ADDR_W-1:0] waddr;
        logic [`ISU_XLEN-1:0] wdata;
    } bypass_t;

    // bit 3 ex2, bit 2 ex1, bit 1 mem2, bit 0 mem1, zero means regfile
    typedef logic [`ISU_NUM_BYPASS-1:0] bypass_src_t;

    typedef struct packed {
        logic valid;
        logic [`ISU_ALU_OP_W-1:0] alu_op;
        logic [`ISU_XLEN-1:0] src1_data;
        logic [`ISU_XLEN-1:0] src2_data;
        bypass_src_t src1_fwd;
        bypass_src_t src2_fwd;
        logic [`ISU_XLEN-1:0] mem_wdata;
        logic [`ISU_XLEN-1:0] pc;
        logic [`ISU_REG_ADDR_W-1:0] dest;
        logic gr_we;
        logic mem_we;
        logic res_from_mem;
        logic is_branch;
        logic pred_taken;
    } issue_t;

endpackage

// ==== design/issue_queue.sv ====
`timescale 1ns/100ps
`include "isu_macros.svh"

module issue_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push_i,
    input  isu_pkg::inst_pair_t pair_i,
    input  logic                pop_i,
    output isu_pkg::inst_pair_t head_o,
    output logic                empty_o,
    output logic                almost_full_o
);

    localparam int PTR_W = $clog2(`ISU_IQ_DEPTH);
    localparam int CNT_W = $clog2(`ISU_IQ_DEPTH + 1);

    isu_pkg::inst_pair_t mem_q [`ISU_IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic full;
    logic push_ok;
    logic pop_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`ISU_IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full          = (count_q == CNT_W'(`ISU_IQ_DEPTH));
    assign empty_o       = (count_q == '0);
    assign almost_full_o = (count_q >= CNT_W'(`ISU_IQ_DEPTH - 1));
    // a push into a full queue is dropped
    assign push_ok       = push_i && !full;
    assign pop_ok        = pop_i && !empty_o;
    assign head_o        = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= pair_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

endmodule

// ==== design/dual_issue_ctrl.sv ====
`timescale 1ns/100ps

module dual_issue_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  isu_pkg::inst_pair_t head_i,
    input  logic                empty_i,
    input  logic                stall_i,
    input  logic                fu1_ready_i,
    input  logic                fu2_ready_i,
    input  logic                load_use_i,
    output logic                pop_o,
    output isu_pkg::slot_req_t  slot1_o,
    output isu_pkg::slot_req_t  slot2_o
);

    typedef enum logic {
        FIRST_SLOT,
        SECOND_SLOT
    } state_e;

    state_e state_q;
    state_e state_d;
    isu_pkg::inst_t first;
    isu_pkg::inst_t second;
    logic rs1_dep;
    logic rs2_dep;
    logic raw_dep;
    logic dual_ok;
    logic go_single;
    logic go;

    assign first  = head_i.first;
    assign second = head_i.second;

    // ----------------------------------------------------------------------
    // hazard check on the head pair
    // ----------------------------------------------------------------------
    assign rs1_dep = !second.src1_is_pc && (second.rs1 == first.dest);
    assign rs2_dep = (!second.src2_is_imm || second.mem_we) && (second.rs2 == first.dest);
    assign raw_dep = first.gr_we && (first.dest != '0) && (rs1_dep || rs2_dep);

    assign dual_ok = !raw_dep
        && !first.is_branch && !second.is_branch
        && !first.mem_we && !first.res_from_mem
        && !second.mem_we && !second.res_from_mem;

    // pairing also needs the second unit
    assign go_single = !stall_i && fu1_ready_i && !load_use_i;
    assign go = (state_q == FIRST_SLOT && dual_ok) ? go_single && fu2_ready_i : go_single;

    // ----------------------------------------------------------------------
    // slot selection and queue pop
    // ----------------------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        pop_o         = 1'b0;
        slot1_o.valid = !empty_i;
        slot1_o.inst  = first;
        slot2_o.valid = 1'b0;
        slot2_o.inst  = second;
        case (state_q)
            FIRST_SLOT: begin
                if (dual_ok) begin
                    slot2_o.valid = !empty_i;
                    pop_o         = !empty_i && go;
                end else if (!empty_i && go) begin
                    // predicted-taken branch kills the younger one
                    if (first.is_branch && first.pred_taken) begin
                        pop_o = 1'b1;
                    end else begin
                        state_d = SECOND_SLOT;
                    end
                end
            end
            SECOND_SLOT: begin
                slot1_o.inst = second;
                if (!empty_i && go) begin
                    pop_o   = 1'b1;
                    state_d = FIRST_SLOT;
                end
            end
            default: state_d = FIRST_SLOT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= FIRST_SLOT;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== design/operand_select.sv ====
`timescale 1ns/100ps
`include "isu_macros.svh"

module operand_select (
    input  isu_pkg::slot_req_t                      slot_i,
    input  isu_pkg::bypass_t [`ISU_NUM_BYPASS-1:0]  bypass_i,
    output logic [`ISU_REG_ADDR_W-1:0]              rf_raddr1_o,
    output logic [`ISU_REG_ADDR_W-1:0]              rf_raddr2_o,
    output logic                                    rf_re1_o,
    output logic                                    rf_re2_o,
    input  logic [`ISU_XLEN-1:0]                    rf_rdata1_i,
    input  logic [`ISU_XLEN-1:0]                    rf_rdata2_i,
    output isu_pkg::issue_t                         issue_o
);

    isu_pkg::inst_t inst;

    // later stages in the loop win, so ex2 beats ex1 beats mem2 beats mem1
    function automatic isu_pkg::bypass_src_t fwd_src(
        input logic [`ISU_REG_ADDR_W-1:0] raddr,
        input isu_pkg::bypass_t [`ISU_NUM_BYPASS-1:0] bypass
    );
        isu_pkg::bypass_src_t src;
        src = '0;
        for (int i = 0; i < `ISU_NUM_BYPASS; i++) begin
            if (raddr != '0 && bypass[i].we && bypass[i].waddr == raddr) begin
                src    = '0;
                src[i] = 1'b1;
            end
        end
        return src;
    endfunction

    assign inst = slot_i.inst;

    // stores read rs2 even with an immediate operand
    assign rf_raddr1_o = (slot_i.valid && !inst.src1_is_pc) ? inst.rs1 : '0;
    assign rf_raddr2_o = (slot_i.valid && (!inst.src2_is_imm || inst.mem_we)) ? inst.rs2 : '0;
    assign rf_re1_o    = (rf_raddr1_o != '0);
    assign rf_re2_o    = (rf_raddr2_o != '0);

    always_comb begin
        issue_o = '0;
        if (slot_i.valid) begin
            issue_o.valid        = 1'b1;
            issue_o.alu_op       = inst.alu_op;
            issue_o.src1_data    = inst.src1_is_pc ? inst.pc : rf_rdata1_i;
            issue_o.src2_data    = inst.src2_is_imm ? inst.imm : rf_rdata2_i;
            issue_o.src1_fwd     = fwd_src(rf_raddr1_o, bypass_i);
            issue_o.src2_fwd     = fwd_src(rf_raddr2_o, bypass_i);
            issue_o.mem_wdata    = rf_rdata2_i;
            issue_o.pc           = inst.pc;
            issue_o.dest         = inst.dest;
            issue_o.gr_we        = inst.gr_we;
            issue_o.mem_we       = inst.mem_we;
            issue_o.res_from_mem = inst.res_from_mem;
            issue_o.is_branch    = inst.is_branch;
            issue_o.pred_taken   = inst.pred_taken;
        end
    end

endmodule

// ==== design/isu_top.sv ====
`timescale 1ns/100ps
`include "isu_macros.svh"

module isu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push_i,
    input  logic [`ISU_ALU_OP_W-1:0]    inst1_alu_op_i,
    input  logic [`ISU_XLEN-1:0]        inst1_imm_i,
    input  logic [`ISU_XLEN-1:0]        inst1_pc_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  inst1_rs1_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  inst1_rs2_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  inst1_dest_i,
    input  logic                        inst1_gr_we_i,
    input  logic                        inst1_mem_we_i,
    input  logic                        inst1_res_from_mem_i,
    input  logic                        inst1_src1_is_pc_i,
    input  logic                        inst1_src2_is_imm_i,
    input  logic                        inst1_is_branch_i,
    input  logic                        inst1_pred_taken_i,
    input  logic [`ISU_ALU_OP_W-1:0]    inst2_alu_op_i,
    input  logic [`ISU_XLEN-1:0]        inst2_imm_i,
    input  logic [`ISU_XLEN-1:0]        inst2_pc_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  inst2_rs1_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  inst2_rs2_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  inst2_dest_i,
    input  logic                        inst2_gr_we_i,
    input  logic                        inst2_mem_we_i,
    input  logic                        inst2_res_from_mem_i,
    input  logic                        inst2_src1_is_pc_i,
    input  logic                        inst2_src2_is_imm_i,
    input  logic                        inst2_is_branch_i,
    input  logic                        inst2_pred_taken_i,
    output logic                        iq_almost_full_o,
    input  logic                        stall_i,
    input  logic                        fu1_ready_i,
    input  logic                        fu2_ready_i,
    input  logic                        load_use_i,
    output logic [`ISU_REG_ADDR_W-1:0]  rf_raddr1_o,
    output logic [`ISU_REG_ADDR_W-1:0]  rf_raddr2_o,
    output logic [`ISU_REG_ADDR_W-1:0]  rf_raddr3_o,
    output logic [`ISU_REG_ADDR_W-1:0]  rf_raddr4_o,
    output logic                        rf_re1_o,
    output logic                        rf_re2_o,
    output logic                        rf_re3_o,
    output logic                        rf_re4_o,
    input  logic [`ISU_XLEN-1:0]        rf_rdata1_i,
    input  logic [`ISU_XLEN-1:0]        rf_rdata2_i,
    input  logic [`ISU_XLEN-1:0]        rf_rdata3_i,
    input  logic [`ISU_XLEN-1:0]        rf_rdata4_i,
    input  logic                        ex1_we_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  ex1_waddr_i,
    input  logic [`ISU_XLEN-1:0]        ex1_wdata_i,
    input  logic                        ex2_we_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  ex2_waddr_i,
    input  logic [`ISU_XLEN-1:0]        ex2_wdata_i,
    input  logic                        mem1_we_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  mem1_waddr_i,
    input  logic [`ISU_XLEN-1:0]        mem1_wdata_i,
    input  logic                        mem2_we_i,
    input  logic [`ISU_REG_ADDR_W-1:0]  mem2_waddr_i,
    input  logic [`ISU_XLEN-1:0]        mem2_wdata_i,
    output logic                        pipe1_valid_o,
    output logic [`ISU_ALU_OP_W-1:0]    pipe1_alu_op_o,
    output logic [`ISU_XLEN-1:0]        pipe1_src1_data_o,
    output logic [`ISU_XLEN-1:0]        pipe1_src2_data_o,
    output logic [`ISU_NUM_BYPASS-1:0]  pipe1_src1_fwd_o,
    output logic [`ISU_NUM_BYPASS-1:0]  pipe1_src2_fwd_o,
    output logic [`ISU_XLEN-1:0]        pipe1_mem_wdata_o,
    output logic [`ISU_XLEN-1:0]        pipe1_pc_o,
    output logic [`ISU_REG_ADDR_W-1:0]  pipe1_dest_o,
    output logic                        pipe1_gr_we_o,
    output logic                        pipe1_mem_we_o,
    output logic                        pipe1_res_from_mem_o,
    output logic                        pipe1_is_branch_o,
    output logic                        pipe1_pred_taken_o,
    output logic                        pipe2_valid_o,
    output logic [`ISU_ALU_OP_W-1:0]    pipe2_alu_op_o,
    output logic [`ISU_XLEN-1:0]        pipe2_src1_data_o,
    output logic [`ISU_XLEN-1:0]        pipe2_src2_data_o,
    output logic [`ISU_NUM_BYPASS-1:0]  pipe2_src1_fwd_o,
    output logic [`ISU_NUM_BYPASS-1:0]  pipe2_src2_fwd_o,
    output logic [`ISU_XLEN-1:0]        pipe2_mem_wdata_o,
    output logic [`ISU_XLEN-1:0]        pipe2_pc_o,
    output logic [`ISU_REG_ADDR_W-1:0]  pipe2_dest_o,
    output logic                        pipe2_gr_we_o,
    output logic                        pipe2_mem_we_o,
    output logic                        pipe2_res_from_mem_o,
    output logic                        pipe2_is_branch_o,
    output logic                        pipe2_pred_taken_o
);

    isu_pkg::inst_pair_t pair_in;
    isu_pkg::inst_pair_t head;
    logic empty;
    logic pop;
    isu_pkg::slot_req_t slot1;
    isu_pkg::slot_req_t slot2;
    isu_pkg::bypass_t [`ISU_NUM_BYPASS-1:0] bypass;
    isu_pkg::issue_t issue1;
    isu_pkg::issue_t issue2;

    // ----------------------------------------------------------------------
    // ports packed in struct field order
    // ----------------------------------------------------------------------
    assign pair_in.first = {inst1_alu_op_i, inst1_imm_i, inst1_pc_i, inst1_rs1_i,
        inst1_rs2_i, inst1_dest_i, inst1_gr_we_i, inst1_mem_we_i, inst1_res_from_mem_i,
        inst1_src1_is_pc_i, inst1_src2_is_imm_i, inst1_is_branch_i, inst1_pred_taken_i};
    assign pair_in.second = {inst2_alu_op_i, inst2_imm_i, inst2_pc_i, inst2_rs1_i,
        inst2_rs2_i, inst2_dest_i, inst2_gr_we_i, inst2_mem_we_i, inst2_res_from_mem_i,
        inst2_src1_is_pc_i, inst2_src2_is_imm_i, inst2_is_branch_i, inst2_pred_taken_i};

    // index matches the bit of the one-hot bypass code
    assign bypass[3] = {ex2_we_i, ex2_waddr_i, ex2_wdata_i};
    assign bypass[2] = {ex1_we_i, ex1_waddr_i, ex1_wdata_i};
    assign bypass[1] = {mem2_we_i, mem2_waddr_i, mem2_wdata_i};
    assign bypass[0] = {mem1_we_i, mem1_waddr_i, mem1_wdata_i};

    assign {pipe1_valid_o, pipe1_alu_op_o, pipe1_src1_data_o, pipe1_src2_data_o,
        pipe1_src1_fwd_o, pipe1_src2_fwd_o, pipe1_mem_wdata_o, pipe1_pc_o, pipe1_dest_o,
        pipe1_gr_we_o, pipe1_mem_we_o, pipe1_res_from_mem_o, pipe1_is_branch_o,
        pipe1_pred_taken_o} = issue1;
    assign {pipe2_valid_o, pipe2_alu_op_o, pipe2_src1_data_o, pipe2_src2_data_o,
        pipe2_src1_fwd_o, pipe2_src2_fwd_o, pipe2_mem_wdata_o, pipe2_pc_o, pipe2_dest_o,
        pipe2_gr_we_o, pipe2_mem_we_o, pipe2_res_from_mem_o, pipe2_is_branch_o,
        pipe2_pred_taken_o} = issue2;

    // ----------------------------------------------------------------------
    // blocks
    // ----------------------------------------------------------------------
    issue_queue i_issue_queue (
        .clk           (clk),
        .rst           (rst),
        .push_i        (push_i),
        .pair_i        (pair_in),
        .pop_i         (pop),
        .head_o        (head),
        .empty_o       (empty),
        .almost_full_o (iq_almost_full_o)
    );

    dual_issue_ctrl i_dual_issue_ctrl (
        .clk         (clk),
        .rst         (rst),
        .head_i      (head),
        .empty_i     (empty),
        .stall_i     (stall_i),
        .fu1_ready_i (fu1_ready_i),
        .fu2_ready_i (fu2_ready_i),
        .load_use_i  (load_use_i),
        .pop_o       (pop),
        .slot1_o     (slot1),
        .slot2_o     (slot2)
    );

    // pipe 1 on read ports 1 and 2
    operand_select i_operand_select_p1 (
        .slot_i      (slot1),
        .bypass_i    (bypass),
        .rf_raddr1_o (rf_raddr1_o),
        .rf_raddr2_o (rf_raddr2_o),
        .rf_re1_o    (rf_re1_o),
        .rf_re2_o    (rf_re2_o),
        .rf_rdata1_i (rf_rdata1_i),
        .rf_rdata2_i (rf_rdata2_i),
        .issue_o     (issue1)
    );

    // pipe 2 on read ports 3 and 4
    operand_select i_operand_select_p2 (
        .slot_i      (slot2),
        .bypass_i    (bypass),
        .rf_raddr1_o (rf_raddr3_o),
        .rf_raddr2_o (rf_raddr4_o),
        .rf_re1_o    (rf_re3_o),
        .rf_re2_o    (rf_re4_o),
        .rf_rdata1_i (rf_rdata3_i),
        .rf_rdata2_i (rf_rdata4_i),
        .issue_o     (issue2)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== dv/tb_isu.sv ====
`timescale 1ns/100ps
`include "isu_macros.svh"

module tb_isu;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_PAIRS      = 400;
    localparam int DEPTH          = `ISU_IQ_DEPTH;
    localparam int TIMEOUT_CYCLES = NUM_PAIRS * 40 + RESET_CYCLES;

    logic clk;
    logic rst;
    logic push_i;
    logic [`ISU_ALU_OP_W-1:0] inst1_alu_op_i, inst2_alu_op_i;
    logic [`ISU_XLEN-1:0] inst1_imm_i, inst1_pc_i, inst2_imm_i, inst2_pc_i;
    logic [`ISU_REG_ADDR_W-1:0] inst1_rs1_i, inst1_rs2_i, inst1_dest_i;
    logic [`ISU_REG_ADDR_W-1:0] inst2_rs1_i, inst2_rs2_i, inst2_dest_i;
    logic inst1_gr_we_i, inst1_mem_we_i, inst1_res_from_mem_i, inst1_src1_is_pc_i;
    logic inst1_src2_is_imm_i, inst1_is_branch_i, inst1_pred_taken_i;
    logic inst2_gr_we_i, inst2_mem_we_i, inst2_res_from_mem_i, inst2_src1_is_pc_i;
    logic inst2_src2_is_imm_i, inst2_is_branch_i, inst2_pred_taken_i;
    logic iq_almost_full_o;
    logic stall_i, fu1_ready_i, fu2_ready_i, load_use_i;
    logic [`ISU_REG_ADDR_W-1:0] rf_raddr1_o, rf_raddr2_o, rf_raddr3_o, rf_raddr4_o;
    logic rf_re1_o, rf_re2_o, rf_re3_o, rf_re4_o;
    logic [`ISU_XLEN-1:0] rf_rdata1_i, rf_rdata2_i, rf_rdata3_i, rf_rdata4_i;
    logic ex1_we_i, ex2_we_i, mem1_we_i, mem2_we_i;
    logic [`ISU_REG_ADDR_W-1:0] ex1_waddr_i, ex2_waddr_i, mem1_waddr_i, mem2_waddr_i;
    logic [`ISU_XLEN-1:0] ex1_wdata_i, ex2_wdata_i, mem1_wdata_i, mem2_wdata_i;
    logic pipe1_valid_o, pipe2_valid_o;
    logic [`ISU_ALU_OP_W-1:0] pipe1_alu_op_o, pipe2_alu_op_o;
    logic [`ISU_XLEN-1:0] pipe1_src1_data_o, pipe1_src2_data_o, pipe1_mem_wdata_o, pipe1_pc_o;
    logic [`ISU_XLEN-1:0] pipe2_src1_data_o, pipe2_src2_data_o, pipe2_mem_wdata_o, pipe2_pc_o;
    logic [`ISU_NUM_BYPASS-1:0] pipe1_src1_fwd_o, pipe1_src2_fwd_o;
    logic [`ISU_NUM_BYPASS-1:0] pipe2_src1_fwd_o, pipe2_src2_fwd_o;
    logic [`ISU_REG_ADDR_W-1:0] pipe1_dest_o, pipe2_dest_o;
    logic pipe1_gr_we_o, pipe1_mem_we_o, pipe1_res_from_mem_o, pipe1_is_branch_o;
    logic pipe2_gr_we_o, pipe2_mem_we_o, pipe2_res_from_mem_o, pipe2_is_branch_o;
    logic pipe1_pred_taken_o, pipe2_pred_taken_o;

    isu_pkg::issue_t act1;
    isu_pkg::issue_t act2;
    logic [`ISU_XLEN-1:0] rf_mem [32];

    // reference model state
    isu_pkg::inst_pair_t model_q[$];
    isu_pkg::inst_pair_t cur_head;
    isu_pkg::inst_pair_t pend_pair;
    logic second_phase;
    logic pend_push;
    logic have;
    logic dual;
    logic go;
    int checks;
    int errors;
    int pushed;
    int issued;
    int dropped;

    tb_clk_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_tb_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    isu_top i_isu_top (.*);

    // register file answers in the same cycle
    assign rf_rdata1_i = rf_mem[rf_raddr1_o];
    assign rf_rdata2_i = rf_mem[rf_raddr2_o];
    assign rf_rdata3_i = rf_mem[rf_raddr3_o];
    assign rf_rdata4_i = rf_mem[rf_raddr4_o];

    assign act1 = {pipe1_valid_o, pipe1_alu_op_o, pipe1_src1_data_o, pipe1_src2_data_o,
        pipe1_src1_fwd_o, pipe1_src2_fwd_o, pipe1_mem_wdata_o, pipe1_pc_o, pipe1_dest_o,
        pipe1_gr_we_o, pipe1_mem_we_o, pipe1_res_from_mem_o, pipe1_is_branch_o,
        pipe1_pred_taken_o};
    assign act2 = {pipe2_valid_o, pipe2_alu_op_o, pipe2_src1_data_o, pipe2_src2_data_o,
        pipe2_src1_fwd_o, pipe2_src2_fwd_o, pipe2_mem_wdata_o, pipe2_pc_o, pipe2_dest_o,
        pipe2_gr_we_o, pipe2_mem_we_o, pipe2_res_from_mem_o, pipe2_is_branch_o,
        pipe2_pred_taken_o};

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    // small register range so dependences show up often
    function automatic isu_pkg::inst_t rand_inst();
        isu_pkg::inst_t inst;
        int kind;
        kind = $urandom % 8;
        inst = '0;
        inst.alu_op = 16'h1 << ($urandom % 16);
        inst.imm = $urandom;
        inst.pc = $urandom & 32'hffff_fffc;
        inst.rs1 = $urandom % 8;
        inst.rs2 = $urandom % 8;
        inst.dest = $urandom % 8;
        inst.gr_we = ($urandom % 4) != 0;
        inst.src1_is_pc = ($urandom % 4) == 0;
        inst.src2_is_imm = ($urandom % 2) == 1;
        case (kind)
            5: begin
                inst.res_from_mem = 1'b1;
                inst.gr_we = 1'b1;
            end
            6: begin
                inst.mem_we = 1'b1;
                inst.gr_we = 1'b0;
            end
            7: begin
                inst.is_branch = 1'b1;
                inst.gr_we = 1'b0;
                inst.pred_taken = ($urandom % 2) == 1;
            end
            default: ;
        endcase
        return inst;
    endfunction

    task automatic drive_inputs();
        isu_pkg::inst_pair_t pair;
        pair.first = rand_inst();
        pair.second = rand_inst();
        // stay below almost-full as seen after this edge
        pend_push = (pushed < NUM_PAIRS) && (model_q.size() < DEPTH - 1)
            && (($urandom % 4) != 0);
        pend_pair = pair;
        if (pend_push) begin
            pushed++;
        end
        push_i <= pend_push;
        {inst1_alu_op_i, inst1_imm_i, inst1_pc_i, inst1_rs1_i, inst1_rs2_i, inst1_dest_i,
            inst1_gr_we_i, inst1_mem_we_i, inst1_res_from_mem_i, inst1_src1_is_pc_i,
            inst1_src2_is_imm_i, inst1_is_branch_i, inst1_pred_taken_i} <= pair.first;
        {inst2_alu_op_i, inst2_imm_i, inst2_pc_i, inst2_rs1_i, inst2_rs2_i, inst2_dest_i,
            inst2_gr_we_i, inst2_mem_we_i, inst2_res_from_mem_i, inst2_src1_is_pc_i,
            inst2_src2_is_imm_i, inst2_is_branch_i, inst2_pred_taken_i} <= pair.second;
        stall_i <= ($urandom % 4) == 0;
        fu1_ready_i <= ($urandom % 5) != 0;
        fu2_ready_i <= ($urandom % 4) != 0;
        load_use_i <= ($urandom % 6) == 0;
        ex1_we_i <= ($urandom % 2) == 1;
        ex1_waddr_i <= $urandom % 8;
        ex1_wdata_i <= $urandom;
        ex2_we_i <= ($urandom % 2) == 1;
        ex2_waddr_i <= $urandom % 8;
        ex2_wdata_i <= $urandom;
        mem1_we_i <= ($urandom % 2) == 1;
        mem1_waddr_i <= $urandom % 8;
        mem1_wdata_i <= $urandom;
        mem2_we_i <= ($urandom % 2) == 1;
        mem2_waddr_i <= $urandom % 8;
        mem2_wdata_i <= $urandom;
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic logic pair_indep(input isu_pkg::inst_pair_t p);
        logic reads1;
        logic reads2;
        logic raw;
        reads1 = !p.second.src1_is_pc;
        reads2 = !p.second.src2_is_imm || p.second.mem_we;
        raw = p.first.gr_we && (p.first.dest != 0)
            && ((reads1 && p.second.rs1 == p.first.dest)
            || (reads2 && p.second.rs2 == p.first.dest));
        return !raw && !p.first.is_branch && !p.second.is_branch
            && !p.first.mem_we && !p.first.res_from_mem
            && !p.second.mem_we && !p.second.res_from_mem;
    endfunction

    function automatic logic [3:0] bypass_tag(input logic [`ISU_REG_ADDR_W-1:0] addr);
        if (addr == 0) begin
            return 4'b0000;
        end
        if (ex2_we_i && ex2_waddr_i == addr) begin
            return 4'b1000;
        end
        if (ex1_we_i && ex1_waddr_i == addr) begin
            return 4'b0100;
        end
        if (mem2_we_i && mem2_waddr_i == addr) begin
            return 4'b0010;
        end
        if (mem1_we_i && mem1_waddr_i == addr) begin
            return 4'b0001;
        end
        return 4'b0000;
    endfunction

    task automatic predict_pipe(input logic valid, input isu_pkg::inst_t inst,
        output isu_pkg::issue_t exp_val, output logic [`ISU_REG_ADDR_W-1:0] addr1,
        output logic [`ISU_REG_ADDR_W-1:0] addr2);
        exp_val = '0;
        addr1 = '0;
        addr2 = '0;
        if (valid) begin
            if (!inst.src1_is_pc) begin
                addr1 = inst.rs1;
            end
            if (!inst.src2_is_imm || inst.mem_we) begin
                addr2 = inst.rs2;
            end
            exp_val.valid = 1'b1;
            exp_val.alu_op = inst.alu_op;
            exp_val.src1_data = inst.src1_is_pc ? inst.pc : rf_mem[addr1];
            exp_val.src2_data = inst.src2_is_imm ? inst.imm : rf_mem[addr2];
            exp_val.src1_fwd = bypass_tag(addr1);
            exp_val.src2_fwd = bypass_tag(addr2);
            exp_val.mem_wdata = rf_mem[addr2];
            exp_val.pc = inst.pc;
            exp_val.dest = inst.dest;
            exp_val.gr_we = inst.gr_we;
            exp_val.mem_we = inst.mem_we;
            exp_val.res_from_mem = inst.res_from_mem;
            exp_val.is_branch = inst.is_branch;
            exp_val.pred_taken = inst.pred_taken;
        end
    endtask

    task automatic update_model();
        if (have && go) begin
            if (second_phase) begin
                model_q.delete(0);
                second_phase = 1'b0;
                issued += 1;
            end else if (dual) begin
                model_q.delete(0);
                issued += 2;
            end else if (cur_head.first.is_branch && cur_head.first.pred_taken) begin
                model_q.delete(0);
                issued += 1;
                dropped += 1;
            end else begin
                second_phase = 1'b1;
                issued += 1;
            end
        end
        if (pend_push) begin
            model_q.push_back(pend_pair);
        end
    endtask

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] act,
        input logic [31:0] exp_val);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, act, exp_val);
        end
    endtask

    task automatic compare_pipe(input string p, input isu_pkg::issue_t act,
        input isu_pkg::issue_t exp_val);
        check_val({p, "valid_o"}, act.valid, exp_val.valid);
        check_val({p, "alu_op_o"}, act.alu_op, exp_val.alu_op);
        check_val({p, "src1_data_o"}, act.src1_data, exp_val.src1_data);
        check_val({p, "src2_data_o"}, act.src2_data, exp_val.src2_data);
        check_val({p, "src1_fwd_o"}, act.src1_fwd, exp_val.src1_fwd);
        check_val({p, "src2_fwd_o"}, act.src2_fwd, exp_val.src2_fwd);
        check_val({p, "mem_wdata_o"}, act.mem_wdata, exp_val.mem_wdata);
        check_val({p, "pc_o"}, act.pc, exp_val.pc);
        check_val({p, "dest_o"}, act.dest, exp_val.dest);
        check_val({p, "gr_we_o"}, act.gr_we, exp_val.gr_we);
        check_val({p, "mem_we_o"}, act.mem_we, exp_val.mem_we);
        check_val({p, "res_from_mem_o"}, act.res_from_mem, exp_val.res_from_mem);
        check_val({p, "is_branch_o"}, act.is_branch, exp_val.is_branch);
        check_val({p, "pred_taken_o"}, act.pred_taken, exp_val.pred_taken);
    endtask

    task automatic check_outputs();
        isu_pkg::issue_t exp1;
        isu_pkg::issue_t exp2;
        logic [`ISU_REG_ADDR_W-1:0] a1, a2, a3, a4;
        have = model_q.size() != 0;
        cur_head = '0;
        if (have) begin
            cur_head = model_q[0];
        end
        dual = have && !second_phase && pair_indep(cur_head);
        go = !stall_i && fu1_ready_i && !load_use_i && (!dual || fu2_ready_i);
        predict_pipe(have, second_phase ? cur_head.second : cur_head.first, exp1, a1, a2);
        predict_pipe(dual, cur_head.second, exp2, a3, a4);
        check_val("iq_almost_full_o", iq_almost_full_o, model_q.size() >= DEPTH - 1);
        check_val("rf_raddr1_o", rf_raddr1_o, a1);
        check_val("rf_raddr2_o", rf_raddr2_o, a2);
        check_val("rf_raddr3_o", rf_raddr3_o, a3);
        check_val("rf_raddr4_o", rf_raddr4_o, a4);
        check_val("rf_re1_o", rf_re1_o, a1 != 0);
        check_val("rf_re2_o", rf_re2_o, a2 != 0);
        check_val("rf_re3_o", rf_re3_o, a3 != 0);
        check_val("rf_re4_o", rf_re4_o, a4 != 0);
        compare_pipe("pipe1_", act1, exp1);
        compare_pipe("pipe2_", act2, exp2);
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        int unsigned seed;
        seed = 32'h3a68_c2ad;
        void'($urandom(seed));
        checks = 0;
        errors = 0;
        pushed = 0;
        issued = 0;
        dropped = 0;
        second_phase = 1'b0;
        pend_push = 1'b0;
        rf_mem[0] = '0;
        for (int i = 1; i < 32; i++) begin
            rf_mem[i] = $urandom;
        end
        push_i <= 1'b0;
        {inst1_alu_op_i, inst1_imm_i, inst1_pc_i, inst1_rs1_i, inst1_rs2_i, inst1_dest_i,
            inst1_gr_we_i, inst1_mem_we_i, inst1_res_from_mem_i, inst1_src1_is_pc_i,
            inst1_src2_is_imm_i, inst1_is_branch_i, inst1_pred_taken_i} <= '0;
        {inst2_alu_op_i, inst2_imm_i, inst2_pc_i, inst2_rs1_i, inst2_rs2_i, inst2_dest_i,
            inst2_gr_we_i, inst2_mem_we_i, inst2_res_from_mem_i, inst2_src1_is_pc_i,
            inst2_src2_is_imm_i, inst2_is_branch_i, inst2_pred_taken_i} <= '0;
        {stall_i, fu1_ready_i, fu2_ready_i, load_use_i} <= 4'b0110;
        {ex1_we_i, ex1_waddr_i, ex1_wdata_i} <= '0;
        {ex2_we_i, ex2_waddr_i, ex2_wdata_i} <= '0;
        {mem1_we_i, mem1_waddr_i, mem1_wdata_i} <= '0;
        {mem2_we_i, mem2_waddr_i, mem2_wdata_i} <= '0;

        @(negedge rst);
        while (!(pushed == NUM_PAIRS && model_q.size() == 0 && !pend_push)) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            update_model();
            drive_inputs();
        end
        // outputs idle once drained
        @(negedge clk);
        check_outputs();

        $display("checks %0d, errors %0d, pairs %0d, issued %0d, dropped %0d",
            checks, errors, pushed, issued, dropped);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the queue did not drain within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
design/isu_pkg.sv
design/issue_queue.sv
design/dual_issue_ctrl.sv
design/operand_select.sv
design/isu_top.sv
dv/tb_clk_gen.sv
dv/tb_isu.sv

// ==== Bender.yml ====
package:
  name: isu

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/isu_pkg.sv
      - design/issue_queue.sv
      - design/dual_issue_ctrl.sv
      - design/operand_select.sv
      - design/isu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_isu.sv
